/* blt.sv */
`timescale 1ns/1ps

module blt import blt_pkg::*; #(
  parameter int ADDR_WIDTH  = 16,
  parameter int BLT_ENTRIES = 16
) (
  input  logic                  clk,
  input  logic                  rst,
  input  blt_update_t           update,
  input  logic                  predict_enable,
  input  logic                  clear_table,
  input  logic [ADDR_WIDTH-1:0] pc,
  output logic [ADDR_WIDTH-1:0] branch_predict,
  output logic                  take_branch
);

  localparam int IDX_W = $clog2(BLT_ENTRIES);
  localparam int TAG_W = ADDR_WIDTH - IDX_W;

  if (BLT_ENTRIES < 2 || (1 << IDX_W) != BLT_ENTRIES) begin : g_entries_check
    $error("BLT_ENTRIES must be a power of two of at least 2");
  end

  typedef struct packed {
    logic [TAG_W-1:0]      tag;
    logic [ADDR_WIDTH-1:0] target;
  } entry_t;

  logic [BLT_ENTRIES-1:0] valid;
  entry_t                 entries [BLT_ENTRIES];

  logic [IDX_W-1:0] upd_idx;
  logic [TAG_W-1:0] upd_tag;
  logic [IDX_W-1:0] rd_idx;
  logic [TAG_W-1:0] rd_tag;
  entry_t           rd_entry;

  assign upd_idx = update.key[IDX_W-1:0];
  assign upd_tag = update.key[ADDR_WIDTH-1:IDX_W];

  // A clear pulse beats an update in the same cycle
  always_ff @(posedge clk) begin
    if (rst || clear_table) begin
      valid <= '0;
    end else if (update.write) begin
      valid[upd_idx] <= update.insert;
    end
  end

  // Tag and target only matter once the valid bit is set
  always_ff @(posedge clk) begin
    if (update.write && update.insert) begin
      entries[upd_idx] <= '{tag: upd_tag, target: update.target};
    end
  end

  // Fetch lookup in the same cycle as pc
  assign rd_idx   = pc[IDX_W-1:0];
  assign rd_tag   = pc[ADDR_WIDTH-1:IDX_W];
  assign rd_entry = entries[rd_idx];

  assign take_branch    = predict_enable && valid[rd_idx] && (rd_entry.tag == rd_tag);
  assign branch_predict = take_branch ? rd_entry.target : '0;

endmodule

/* blt_ctrl_regs.sv */
`timescale 1ns/1ps

module blt_ctrl_regs import blt_pkg::*; #(
  parameter int MISS_COUNT_WIDTH = 16
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        cfg_write,
  input  blt_cfg_t                    cfg,
  input  logic                        miss,
  output logic                        predict_enable,
  output logic                        clear_table,
  output logic [MISS_COUNT_WIDTH-1:0] miss_count
);

  blt_cfg_t cfg_q;

  // Enable follows the strobe, clear lives for exactly one cycle after it
  always_ff @(posedge clk) begin
    if (rst) begin
      cfg_q <= CFG_RESET;
    end else begin
      cfg_q.clear <= cfg_write && cfg.clear;
      if (cfg_write) begin
        cfg_q.predict_enable <= cfg.predict_enable;
      end
    end
  end

  assign predict_enable = cfg_q.predict_enable;
  assign clear_table    = cfg_q.clear;

  // Saturating count of mispredictions, zeroed together with the table
  always_ff @(posedge clk) begin
    if (rst || clear_table) begin
      miss_count <= '0;
    end else if (miss && (miss_count != '1)) begin
      miss_count <= miss_count + 1'b1;
    end
  end

endmodule

/* blt_pkg.sv */
package blt_pkg;
  import branch_pkg::*;

  // Written as a whole by the configuration strobe
  typedef struct packed {
    logic predict_enable;
    logic clear;
  } blt_cfg_t;

  // One table write per cycle, raised by the branch unit on a misprediction
  // insert set makes the entry valid with this target, insert clear drops it
  typedef struct packed {
    logic  write;
    logic  insert;
    addr_t key;
    addr_t target;
  } blt_update_t;

  localparam blt_cfg_t CFG_RESET = '{predict_enable: 1'b0, clear: 1'b0};

endpackage

/* branch_pkg.sv */
package branch_pkg;

  // Address width that sizes the shared structs
  // The modules take ADDR_WIDTH as a parameter that has to agree with it
  localparam int DEFAULT_ADDR_WIDTH = 16;

  typedef logic [DEFAULT_ADDR_WIDTH-1:0] addr_t;

  // Conditional opcodes sit in one contiguous range, JMP_OP_JEQ through JMP_OP_JNZ
  typedef enum logic [3:0] {
    JMP_OP_NOP = 4'd0,
    JMP_OP_J   = 4'd1,
    JMP_OP_JR  = 4'd2,
    JMP_OP_JEQ = 4'd3,
    JMP_OP_JNE = 4'd4,
    JMP_OP_JL  = 4'd5,
    JMP_OP_JLE = 4'd6,
    JMP_OP_JG  = 4'd7,
    JMP_OP_JGE = 4'd8,
    JMP_OP_JZ  = 4'd9,
    JMP_OP_JNZ = 4'd10
  } jop_t;

  typedef struct packed {
    logic zero;
    logic less;
    logic greater;
  } cmp_flags_t;

  // Branch instruction as it sits in the ID/EX register
  typedef struct packed {
    addr_t pc;
    addr_t reg_address;
    addr_t imm_address;
    jop_t  jop;
    logic  branch_taken;
  } ex_branch_t;

  typedef struct packed {
    logic ex_mem;
    logic id_ex;
    logic if_id;
    logic pc;
  } flush_mask_t;

  localparam flush_mask_t FLUSH_NONE   = '{ex_mem: 1'b0, id_ex: 1'b0, if_id: 1'b0, pc: 1'b0};
  localparam flush_mask_t FLUSH_EX_MEM = '{ex_mem: 1'b1, id_ex: 1'b0, if_id: 1'b0, pc: 1'b0};
  localparam flush_mask_t FLUSH_ALL    = '{ex_mem: 1'b1, id_ex: 1'b1, if_id: 1'b1, pc: 1'b1};

  function automatic logic is_conditional(jop_t op);
    return op inside {[JMP_OP_JEQ:JMP_OP_JNZ]};
  endfunction

endpackage

/* branch_resolve_assertions.sv */
`timescale 1ns/1ps

module branch_resolve_assertions import branch_pkg::*; (
  input logic        clk,
  input logic        rst,
  input jop_t        jop,
  input flush_mask_t flush,
  input logic        update_write
);

  // A redirect of fetch always drops everything behind the branch
  a_pc_flush_all: assert property (@(posedge clk) disable iff (rst)
    flush.pc |-> (flush == 4'b1111))
    else $error("pc flush without the full flush mask");

  a_update_conditional: assert property (@(posedge clk) disable iff (rst)
    update_write |-> (jop >= JMP_OP_JEQ && jop <= JMP_OP_JNZ))
    else $error("table update from an unconditional opcode");

  a_nop_no_flush: assert property (@(posedge clk) disable iff (rst)
    (jop == JMP_OP_NOP) |-> (flush == 4'b0000))
    else $error("flush raised for a NOP");

endmodule

/* branch_resolve_top.sv */
`timescale 1ns/1ps

module branch_resolve_top import branch_pkg::*; import blt_pkg::*; #(
  parameter int ADDR_WIDTH       = 16,
  parameter int BLT_ENTRIES      = 16,
  parameter int MISS_COUNT_WIDTH = 16
) (
  input  logic                        clk,
  input  logic                        rst,
  input  cmp_flags_t                  flags,
  input  ex_branch_t                  ex,
  input  logic [ADDR_WIDTH-1:0]       pc,
  input  logic                        cfg_write,
  input  blt_cfg_t                    cfg,
  output flush_mask_t                 flush,
  output logic [ADDR_WIDTH-1:0]       jump_address,
  output logic [ADDR_WIDTH-1:0]       branch_predict,
  output logic                        take_branch,
  output logic [MISS_COUNT_WIDTH-1:0] miss_count
);

  if (ADDR_WIDTH != DEFAULT_ADDR_WIDTH) begin : g_width_check
    $error("ADDR_WIDTH must match the address width of the shared structs");
  end

  blt_update_t update;
  logic        predict_enable;
  logic        clear_table;

  branch_unit #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) branch_unit0 (
    .flags       (flags),
    .ex          (ex),
    .flush       (flush),
    .jump_address(jump_address),
    .update      (update)
  );

  // Every table write is one misprediction
  blt_ctrl_regs #(
    .MISS_COUNT_WIDTH(MISS_COUNT_WIDTH)
  ) blt_ctrl_regs0 (
    .clk           (clk),
    .rst           (rst),
    .cfg_write     (cfg_write),
    .cfg           (cfg),
    .miss          (update.write),
    .predict_enable(predict_enable),
    .clear_table   (clear_table),
    .miss_count    (miss_count)
  );

  blt #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .BLT_ENTRIES(BLT_ENTRIES)
  ) blt0 (
    .clk           (clk),
    .rst           (rst),
    .update        (update),
    .predict_enable(predict_enable),
    .clear_table   (clear_table),
    .pc            (pc),
    .branch_predict(branch_predict),
    .take_branch   (take_branch)
  );

endmodule

/* branch_unit.sv */
`timescale 1ns/1ps

module branch_unit import branch_pkg::*; import blt_pkg::*; #(
  parameter int ADDR_WIDTH = 16
) (
  input  cmp_flags_t            flags,
  input  ex_branch_t            ex,
  output flush_mask_t           flush,
  output logic [ADDR_WIDTH-1:0] jump_address,
  output blt_update_t           update
);

  logic branch_cond;
  logic conditional;
  logic mispredict;
  logic both_taken;

  // Condition of the branch in ID/EX against the ALU flags
  always_comb begin
    case (ex.jop)
      JMP_OP_JEQ: branch_cond = flags.zero;
      JMP_OP_JZ:  branch_cond = flags.zero;
      JMP_OP_JNE: branch_cond = !flags.zero;
      JMP_OP_JNZ: branch_cond = !flags.zero;
      JMP_OP_JL:  branch_cond = flags.less;
      JMP_OP_JLE: branch_cond = flags.less || flags.zero;
      JMP_OP_JG:  branch_cond = flags.greater;
      JMP_OP_JGE: branch_cond = flags.greater || flags.zero;
      default:    branch_cond = 1'b0;
    endcase
  end

  assign conditional = is_conditional(ex.jop);

  // Fetch followed the wrong path when outcome and prediction differ
  assign mispredict = conditional && (branch_cond != ex.branch_taken);
  assign both_taken = conditional && branch_cond && ex.branch_taken;

  // A register jump is never predicted, so everything behind it goes
  always_comb begin
    if (ex.jop == JMP_OP_JR || mispredict) begin
      flush = FLUSH_ALL;
    end else if (ex.jop == JMP_OP_J || both_taken) begin
      flush = FLUSH_EX_MEM;
    end else begin
      flush = FLUSH_NONE;
    end
  end

  // Redirect target
  // A predicted branch that falls through resumes right after itself
  always_comb begin
    if (ex.jop == JMP_OP_JR) begin
      jump_address = ex.reg_address;
    end else if (conditional && ex.branch_taken && !branch_cond) begin
      jump_address = ex.pc + 1'b1;
    end else begin
      jump_address = ex.imm_address;
    end
  end

  // Taken but not predicted is learned, predicted but not taken is forgotten
  always_comb begin
    update.write  = mispredict;
    update.insert = branch_cond;
    update.key    = ex.pc;
    update.target = jump_address;
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run with Verilator, then decide by the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_branch_resolve \
  -f src.f -o tb_sim > sim.log 2>&1 \
  && ./obj_dir/tb_sim >> sim.log 2>&1 \
  || echo "Test failures found" >> sim.log
cat sim.log
grep -q "Test failures found" sim.log && echo "FAIL" && exit 1
grep -q "All tests passed!" sim.log || exit 1
echo "PASS"
exit 0

/* src.f */
branch_pkg.sv
blt_pkg.sv
blt.sv
blt_ctrl_regs.sv
branch_unit.sv
branch_resolve_top.sv
branch_resolve_assertions.sv
tb_branch_resolve.sv

/* tb_branch_resolve.sv */
`timescale 1ns/1ps

module tb_branch_resolve import branch_pkg::*, blt_pkg::*; ();

  localparam int BLT_ENTRIES   = 16;
  localparam int COUNT_WIDTH   = 16;
  localparam int IDX_W         = $clog2(BLT_ENTRIES);
  localparam int RANDOM_CYCLES = 3000;
  localparam int RESET_TIMEOUT = 50;

  localparam blt_cfg_t   CFG_IDLE  = '{predict_enable: 1'b0, clear: 1'b0};
  localparam blt_cfg_t   CFG_ON    = '{predict_enable: 1'b1, clear: 1'b0};
  localparam blt_cfg_t   CFG_CLEAR = '{predict_enable: 1'b1, clear: 1'b1};
  localparam cmp_flags_t ZERO_SET  = '{zero: 1'b1, less: 1'b0, greater: 1'b0};

  logic                   clk;
  logic                   rst;
  cmp_flags_t             flags;
  ex_branch_t             ex;
  addr_t                  pc;
  logic                   cfg_write;
  blt_cfg_t               cfg;
  flush_mask_t            flush;
  addr_t                  jump_address;
  addr_t                  branch_predict;
  logic                   take_branch;
  logic [COUNT_WIDTH-1:0] miss_count;

  // Reference copy of the table and the control registers
  logic                   m_valid [BLT_ENTRIES];
  addr_t                  m_key [BLT_ENTRIES];
  addr_t                  m_target [BLT_ENTRIES];
  logic                   m_enable;
  logic                   m_clear;
  logic [COUNT_WIDTH-1:0] m_count;

  branch_resolve_top dut0 (.*);

  bind branch_resolve_top branch_resolve_assertions assertions0 (
    .clk(clk), .rst(rst), .jop(ex.jop), .flush(flush), .update_write(update.write)
  );

  always #5 clk = ~clk;

  initial begin
    rst = 1'b1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

  function automatic logic cond_op(jop_t op);
    return op inside {JMP_OP_JEQ, JMP_OP_JNE, JMP_OP_JL, JMP_OP_JLE,
                      JMP_OP_JG, JMP_OP_JGE, JMP_OP_JZ, JMP_OP_JNZ};
  endfunction

  function automatic logic cond_value(jop_t op, cmp_flags_t f);
    case (op)
      JMP_OP_JEQ, JMP_OP_JZ:  return f.zero;
      JMP_OP_JNE, JMP_OP_JNZ: return !f.zero;
      JMP_OP_JL:              return f.less;
      JMP_OP_JLE:             return f.less || f.zero;
      JMP_OP_JG:              return f.greater;
      JMP_OP_JGE:             return f.greater || f.zero;
      default:                return 1'b0;
    endcase
  endfunction

  // Mask bits are ex_mem, id_ex, if_id, pc from the top
  function automatic flush_mask_t flush_rule(jop_t op, logic cond, logic taken);
    if (op == JMP_OP_JR || (cond_op(op) && cond != taken))
      return 4'b1111;
    else if (op == JMP_OP_J || (cond_op(op) && cond))
      return 4'b1000;
    else
      return 4'b0000;
  endfunction

  function automatic addr_t jump_rule(ex_branch_t e, logic cond);
    if (e.jop == JMP_OP_JR)
      return e.reg_address;
    else if (cond_op(e.jop) && e.branch_taken && !cond)
      return e.pc + 16'd1;
    else
      return e.imm_address;
  endfunction

  task automatic report_mismatch(string msg);
    $display("error at %0t: %s", $time, msg);
    $display("Test failures found");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic check_flush(flush_mask_t got, flush_mask_t exp, string what);
    if (got !== exp)
      report_mismatch($sformatf("%s flush %b, expected %b", what, got, exp));
  endtask

  task automatic check_addr(addr_t got, addr_t exp, string what);
    if (got !== exp)
      report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
  endtask

  task automatic check_bit(logic got, logic exp, string what);
    if (got !== exp)
      report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  task automatic check_count(logic [COUNT_WIDTH-1:0] got, logic [COUNT_WIDTH-1:0] exp,
                             string what);
    if (got !== exp)
      report_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
  endtask

  // Each cycle drives at the falling edge, checks, then advances the model past the rising edge
  task automatic step(cmp_flags_t f, ex_branch_t e, addr_t fetch_pc, logic wr, blt_cfg_t c);
    logic  cond;
    logic  miss;
    logic  hit;
    addr_t exp_jump;
    int    idx;
    int    widx;
    @(negedge clk);
    flags     = f;
    ex        = e;
    pc        = fetch_pc;
    cfg_write = wr;
    cfg       = c;
    #1;
    cond     = cond_value(e.jop, f);
    miss     = cond_op(e.jop) && (cond != e.branch_taken);
    exp_jump = jump_rule(e, cond);
    idx      = int'(fetch_pc[IDX_W-1:0]);
    hit      = m_enable && m_valid[idx] && (m_key[idx] == fetch_pc);
    check_flush(flush, flush_rule(e.jop, cond, e.branch_taken), "resolution");
    check_addr(jump_address, exp_jump, "jump_address");
    check_bit(take_branch, hit, "take_branch");
    check_addr(branch_predict, hit ? m_target[idx] : 16'h0, "branch_predict");
    check_count(miss_count, m_count, "miss_count");
    if (m_clear) begin
      m_count = '0;
      foreach (m_valid[k])
        m_valid[k] = 1'b0;
    end else if (miss) begin
      widx = int'(e.pc[IDX_W-1:0]);
      if (m_count != '1)
        m_count = m_count + 1'b1;
      m_valid[widx] = cond;
      if (cond) begin
        m_key[widx]    = e.pc;
        m_target[widx] = exp_jump;
      end
    end
    m_clear = wr && c.clear;
    if (wr)
      m_enable = c.predict_enable;
  endtask

  initial begin
    int          waited;
    addr_t       pool [8];
    ex_branch_t  e;
    blt_cfg_t    c;
    clk       = 1'b0;
    flags     = '0;
    ex        = '0;
    pc        = '0;
    cfg_write = 1'b0;
    cfg       = CFG_IDLE;
    m_enable  = 1'b0;
    m_clear   = 1'b0;
    m_count   = '0;
    foreach (m_valid[k])
      m_valid[k] = 1'b0;
    $timeformat(-9, 0, " ns", 0);
    void'($urandom(32'h492b15b0));
    foreach (pool[k])
      pool[k] = addr_t'($urandom);

    waited = 0;
    while (rst !== 1'b0 && waited < RESET_TIMEOUT) begin
      @(negedge clk);
      #1;
      waited++;
    end
    if (rst !== 1'b0) begin
      $display("Reset was still asserted after %0d cycles", waited);
      $display("Test failures found");
      $fatal(1, "reset wait timed out");
    end

    step('0, '0, 16'h0, 1'b0, CFG_IDLE);
    check_bit(take_branch, 1'b0, "take_branch after reset");
    check_count(miss_count, '0, "miss_count after reset");
    check_flush(flush, 4'b0000, "NOP after reset");

    // Every opcode against every flag pattern, predicted and not
    for (int op = 0; op <= 10; op++)
      for (int fl = 0; fl < 8; fl++)
        for (int tk = 0; tk < 2; tk++)
          step(cmp_flags_t'(fl[2:0]), '{addr_t'($urandom), addr_t'($urandom),
               addr_t'($urandom), jop_t'(op[3:0]), tk[0]}, addr_t'($urandom), 1'b0, CFG_IDLE);

    step('0, '0, 16'h0, 1'b1, CFG_ON);
    step(ZERO_SET, '{16'h1234, 16'h0, 16'h4321, JMP_OP_JEQ, 1'b0}, 16'h0, 1'b0, CFG_IDLE);
    step('0, '0, 16'h1234, 1'b0, CFG_IDLE);
    check_bit(take_branch, 1'b1, "lookup of a learned branch");
    check_addr(branch_predict, 16'h4321, "target of a learned branch");
    step(ZERO_SET, '{16'h1234, 16'h0, 16'h4321, JMP_OP_JNE, 1'b1}, 16'h1234, 1'b0, CFG_IDLE);
    step('0, '0, 16'h1234, 1'b0, CFG_IDLE);
    check_bit(take_branch, 1'b0, "lookup of a forgotten branch");

    // Disable keeps the contents, enable brings the hit back
    step(ZERO_SET, '{16'h1234, 16'h0, 16'h4321, JMP_OP_JEQ, 1'b0}, 16'h0, 1'b1, CFG_IDLE);
    step('0, '0, 16'h1234, 1'b0, CFG_IDLE);
    check_bit(take_branch, 1'b0, "lookup while disabled");
    step('0, '0, 16'h1234, 1'b1, CFG_ON);
    step('0, '0, 16'h1234, 1'b0, CFG_IDLE);
    check_bit(take_branch, 1'b1, "lookup after re-enable");

    step('0, '0, 16'h1234, 1'b1, CFG_CLEAR);
    step('0, '0, 16'h1234, 1'b0, CFG_IDLE);
    step('0, '0, 16'h1234, 1'b0, CFG_IDLE);
    check_bit(take_branch, 1'b0, "lookup after table clear");
    check_count(miss_count, '0, "miss_count after table clear");

    // One misprediction more than the counter can hold runs it into saturation
    for (int i = 0; i < (1 << COUNT_WIDTH); i++)
      step(ZERO_SET, '{addr_t'($urandom), 16'h0, addr_t'($urandom), JMP_OP_JEQ, 1'b0},
           16'h0, 1'b0, CFG_IDLE);
    step('0, '0, 16'h0, 1'b0, CFG_IDLE);
    check_count(miss_count, '1, "saturated miss_count");

    for (int i = 0; i < RANDOM_CYCLES; i++) begin
      if ($urandom_range(0, 49) == 0)
        pool[$urandom_range(0, 7)] = addr_t'($urandom);
      e = '{pool[$urandom_range(0, 7)], addr_t'($urandom), addr_t'($urandom),
            jop_t'($urandom_range(0, 10)), ($urandom_range(0, 1) == 1)};
      c = '{($urandom_range(0, 3) != 0), ($urandom_range(0, 9) == 0)};
      step(cmp_flags_t'($urandom_range(0, 7)), e,
           ($urandom_range(0, 9) < 6) ? pool[$urandom_range(0, 7)] : addr_t'($urandom),
           ($urandom_range(0, 99) < 3), c);
    end

    $display("All tests passed!");
    $finish;
  end

endmodule
